//--- list.f
+incdir+testbench
verilog/tetris_pkg.sv
verilog/cmd_queue.sv
verilog/piece_geometry.sv
verilog/piece_sequencer.sv
verilog/board_store.sv
verilog/game_ctrl.sv
verilog/tetris_top.sv
testbench/tb_tetris.sv

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// dx,dy of blocks 1 to 3 around the centre at orientation 0
int shape_offs [NUM_SHAPES][6] = '{
    '{-1, 0, 1, 0, 2, 0},
    '{1, 0, 0, 1, 1, 1},
    '{-1, 0, 1, 0, 0, 1},
    '{1, 0, -1, 1, 0, 1},
    '{-1, 0, 0, 1, 1, 1},
    '{-1, 0, 1, 0, 1, 1},
    '{-1, 0, 1, 0, -1, 1}
};

int board_m [BOARD_ROWS][BOARD_COLS];
int seq_list [NUM_SHAPES];
int seq_adv;
int m_shape;
int m_dir;
int m_col;
int m_row;

// column or row of block k, block 0 being the centre
function automatic int cell_at(input int s, input int d, input int c, input int r,
                               input int k, input bit want_row);
    int dx;
    int dy;
    int t;
    dx = 0;
    dy = 0;
    if (k > 0) begin
        dx = shape_offs[s][2*k-2];
        dy = shape_offs[s][2*k-1];
    end
    for (int i = 0; i < d; i++) begin
        t = dx;
        dx = -dy;
        dy = t;
    end
    return want_row ? r + dy : c + dx;
endfunction

function automatic bit fits_at(input int s, input int d, input int c, input int r);
    int x;
    int y;
    for (int k = 0; k < 4; k++) begin
        x = cell_at(s, d, c, r, k, 1'b0);
        y = cell_at(s, d, c, r, k, 1'b1);
        if (x < 0 || x >= BOARD_COLS || y < 0 || y >= BOARD_ROWS) begin
            return 1'b0;
        end
        if (board_m[y][x] != 0) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

function automatic int points_for(input int lines);
    case (lines)
        1: return 1;
        2: return 3;
        3: return 5;
        4: return 7;
        default: return 0;
    endcase
endfunction

// full rows vanish, the rest settle to the bottom
function automatic int clear_rows();
    int n;
    int dst;
    bit full;
    n = 0;
    dst = BOARD_ROWS - 1;
    for (int r = BOARD_ROWS - 1; r >= 0; r--) begin
        full = 1'b1;
        for (int c = 0; c < BOARD_COLS; c++) begin
            if (board_m[r][c] == 0) begin
                full = 1'b0;
            end
        end
        if (full) begin
            n++;
        end else begin
            for (int c = 0; c < BOARD_COLS; c++) begin
                board_m[dst][c] = board_m[r][c];
            end
            dst--;
        end
    end
    for (int r = dst; r >= 0; r--) begin
        for (int c = 0; c < BOARD_COLS; c++) begin
            board_m[r][c] = 0;
        end
    end
    return n;
endfunction

function automatic void seq_advance();
    int old [NUM_SHAPES];
    old = seq_list;
    if (seq_adv == NUM_SHAPES - 1) begin
        seq_list = '{old[3], old[5], old[4], old[0], old[6], old[2], old[1]};
        seq_adv = 0;
    end else begin
        for (int i = 0; i < NUM_SHAPES; i++) begin
            seq_list[i] = old[(i + 1) % NUM_SHAPES];
        end
        seq_adv++;
    end
endfunction

function automatic void model_clear_board();
    for (int r = 0; r < BOARD_ROWS; r++) begin
        for (int c = 0; c < BOARD_COLS; c++) begin
            board_m[r][c] = 0;
        end
    end
endfunction

function automatic void model_reset();
    for (int i = 0; i < NUM_SHAPES; i++) begin
        seq_list[i] = i;
    end
    seq_adv = 0;
    model_clear_board();
endfunction

function automatic void model_spawn();
    m_shape = seq_list[0];
    m_dir = 0;
    m_col = SPAWN_COL;
    m_row = 0;
endfunction

function automatic void model_move(input cmd_e c);
    int nc;
    int nd;
    nc = m_col + ((c == CMD_RIGHT) ? 1 : 0) - ((c == CMD_LEFT) ? 1 : 0);
    nd = (c == CMD_ROTATE) ? (m_dir + 1) % 4 : m_dir;
    // blocked moves leave the piece where it was
    if (fits_at(m_shape, nd, nc, m_row)) begin
        m_col = nc;
        m_dir = nd;
    end
endfunction

// hard drop, place, clear; returns rows removed
function automatic int model_drop();
    while (fits_at(m_shape, m_dir, m_col, m_row + 1)) begin
        m_row++;
    end
    for (int k = 0; k < 4; k++) begin
        board_m[cell_at(m_shape, m_dir, m_col, m_row, k, 1'b1)]
               [cell_at(m_shape, m_dir, m_col, m_row, k, 1'b0)] = m_shape + 1;
    end
    return clear_rows();
endfunction

// column where the piece lands deepest
function automatic int aim_col();
    int best;
    int best_depth;
    int r;
    int depth;
    best = m_col;
    best_depth = -1;
    for (int c = 0; c < BOARD_COLS; c++) begin
        if (fits_at(m_shape, m_dir, c, m_row)) begin
            r = m_row;
            while (fits_at(m_shape, m_dir, c, r + 1)) begin
                r++;
            end
            depth = 0;
            for (int k = 0; k < 4; k++) begin
                depth += cell_at(m_shape, m_dir, c, r, k, 1'b1);
            end
            if (depth > best_depth) begin
                best_depth = depth;
                best = c;
            end
        end
    end
    return best;
endfunction

`endif

//--- testbench/tb_tetris.sv
`timescale 1ns/1ps

module tb_tetris;
    import tetris_pkg::*;

    localparam int N_MAIN     = 40;
    localparam int N_STACK    = 40;
    localparam int N_PIECES   = N_MAIN + N_STACK + 2;
    localparam int LAND_LIMIT = 2000;

    logic               i_clk;
    logic               i_rst_n;
    logic               i_start;
    logic               i_stop;
    logic               i_cmd_valid;
    cmd_e               i_cmd;
    logic [COL_W-1:0]   i_rd_col;
    logic [ROW_W-1:0]   i_rd_row;
    logic               o_cmd_credit;
    logic [COLOR_W-1:0] o_rd_cell;
    land_report_t       o_land;
    logic [9:0]         o_score;
    logic               o_finish;

    int   sent;
    int   returned;
    int   score_exp;
    bit   game_over;
    cmd_e moves [$];

    `include "tb_model.svh"

    tetris_top dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_stop       (i_stop),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .i_rd_col     (i_rd_col),
        .i_rd_row     (i_rd_row),
        .o_cmd_credit (o_cmd_credit),
        .o_rd_cell    (o_rd_cell),
        .o_land       (o_land),
        .o_score      (o_score),
        .o_finish     (o_finish)
    );

    always #50 i_clk = ~i_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // credit pulses seen at the edge that ends them
    always @(posedge i_clk) begin
        if (i_rst_n && o_cmd_credit === 1'b1) begin
            returned++;
            check(returned <= sent, 1, "credit returned without a command");
        end
    end

    initial begin
        repeat (N_PIECES * (FALL_TICKS + 200)) @(posedge i_clk);
        abort_run("timeout: the tests did not complete within the cycle budget");
    end

    task automatic send_cmd(input cmd_e c);
        int guard;
        guard = 0;
        while (sent - returned >= CMD_DEPTH) begin
            @(negedge i_clk);
            guard++;
            if (guard > LAND_LIMIT) begin
                abort_run("no credit came back for a queued command");
            end
        end
        i_cmd_valid = 1'b1;
        i_cmd = c;
        sent++;
        @(negedge i_clk);
        i_cmd_valid = 1'b0;
    endtask

    task automatic read_cell(input int c, input int r, output logic [COLOR_W-1:0] v);
        i_rd_col = COL_W'(c);
        i_rd_row = ROW_W'(r);
        @(negedge i_clk);
        v = o_rd_cell;
    endtask

    task automatic compare_board();
        logic [COLOR_W-1:0] v;
        for (int r = 0; r < BOARD_ROWS; r++) begin
            for (int c = 0; c < BOARD_COLS; c++) begin
                read_cell(c, r, v);
                check(v, board_m[r][c], $sformatf("cell col %0d row %0d", c, r));
                check(o_land.valid, 0, "land pulse while idle");
                check(o_finish, 0, "finish pulse while idle");
            end
        end
    endtask

    task automatic start_game();
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        model_clear_board();
        model_spawn();
        score_exp = 0;
        game_over = 1'b0;
        repeat (2) @(negedge i_clk);
        check(o_score, 0, "score after start");
    endtask

    function automatic void aim_moves();
        int target;
        target = aim_col();
        for (int c = m_col; c > target; c--) begin
            moves.push_back(CMD_LEFT);
        end
        for (int c = m_col; c < target; c++) begin
            moves.push_back(CMD_RIGHT);
        end
    endfunction

    task automatic wait_land();
        int n;
        n = 0;
        while (o_land.valid !== 1'b1) begin
            @(negedge i_clk);
            n++;
            if (n > LAND_LIMIT) begin
                abort_run("the land pulse never arrived after a drop");
            end
        end
    endtask

    // sends the queued moves and a drop, then checks the landing
    task automatic play_piece();
        cmd_e c;
        int   lines;
        while (moves.size() > 0) begin
            c = moves.pop_front();
            model_move(c);
            send_cmd(c);
        end
        send_cmd(CMD_DROP);
        lines = model_drop();
        score_exp += points_for(lines);
        wait_land();
        check(o_land.lines, lines, "rows removed");
        check(o_score, score_exp, "score");
        seq_advance();
        model_spawn();
        game_over = !fits_at(m_shape, m_dir, m_col, m_row);
        // finish follows the land pulse by one cycle
        @(negedge i_clk);
        check(o_finish, game_over, "game over pulse");
        @(negedge i_clk);
        compare_board();
    endtask

    initial begin
        int                 n;
        int                 seed;
        cmd_e               side;
        logic [COLOR_W-1:0] v;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_stop = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd = CMD_LEFT;
        i_rd_col = '0;
        i_rd_row = '0;
        sent = 0;
        returned = 0;
        score_exp = 0;
        game_over = 1'b0;
        seed = $urandom(29);
        model_reset();
        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check(o_score, 0, "score after reset");
        compare_board();

        // untouched I piece lands flat on the floor
        start_game();
        play_piece();
        for (int c = 3; c <= 6; c++) begin
            read_cell(c, BOARD_ROWS - 1, v);
            check(v, 1, $sformatf("first I block at col %0d", c));
        end

        for (int p = 0; p < N_MAIN; p++) begin
            if (game_over) begin
                start_game();
            end
            if ($urandom % 4 == 0) begin
                // one gravity step first so rotations have room
                if (fits_at(m_shape, m_dir, m_col, m_row + 1)) begin
                    repeat (FALL_TICKS) @(negedge i_clk);
                    m_row++;
                end
                n = $urandom % 4;
                side = ($urandom % 2 == 0) ? CMD_LEFT : CMD_RIGHT;
                // the last shifts run into the side wall
                repeat (6) moves.push_back(side);
                repeat (n) moves.push_back(cmd_e'($urandom % 3));
            end else begin
                aim_moves();
            end
            play_piece();
        end

        // pile up at the spawn column until no piece fits
        if (game_over) begin
            start_game();
        end
        n = 0;
        while (!game_over) begin
            play_piece();
            n++;
            if (n > N_STACK) begin
                abort_run("stacking at the spawn column never ended the game");
            end
        end
        send_cmd(CMD_RIGHT);
        repeat (3) @(negedge i_clk);
        start_game();
        compare_board();

        repeat (4) @(negedge i_clk);
        check(CMD_DEPTH - sent + returned, CMD_DEPTH, "credits held by the sender");
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog/tetris_top.sv
`timescale 1ns/1ps

module tetris_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_start,
    input  logic                           i_stop,
    input  logic                           i_cmd_valid,
    input  tetris_pkg::cmd_e               i_cmd,
    input  logic [tetris_pkg::COL_W-1:0]   i_rd_col,
    input  logic [tetris_pkg::ROW_W-1:0]   i_rd_row,
    output logic                           o_cmd_credit,
    output logic [tetris_pkg::COLOR_W-1:0] o_rd_cell,
    output tetris_pkg::land_report_t       o_land,
    output logic [9:0]                     o_score,
    output logic                           o_finish
);
    import tetris_pkg::*;

    logic         q_valid;
    cmd_e         q_cmd;
    logic         pop;
    piece_pos_t   active_pos;
    piece_pos_t   probe_pos;
    piece_cells_t active_cells;
    piece_cells_t probe_cells;
    shape_t       cur_shape;
    logic         fits;
    logic         place;
    logic         clear;
    logic         scan_start;
    logic         scan_done;
    logic         next;
    logic [2:0]   lines;

    cmd_queue u_cmd_queue (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_push   (i_cmd_valid),
        .i_cmd    (i_cmd),
        .i_pop    (pop),
        .o_valid  (q_valid),
        .o_cmd    (q_cmd),
        .o_credit (o_cmd_credit)
    );

    piece_geometry geom_active (
        .i_pos   (active_pos),
        .o_cells (active_cells)
    );

    piece_geometry geom_probe (
        .i_pos   (probe_pos),
        .o_cells (probe_cells)
    );

    piece_sequencer u_sequencer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_next  (next),
        .o_shape (cur_shape)
    );

    // stored colour is shape number plus one
    board_store u_board (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_clear       (clear),
        .i_probe       (probe_cells),
        .i_place       (place),
        .i_place_cells (active_cells),
        .i_place_color (COLOR_W'(active_pos.shape + 3'd1)),
        .i_scan_start  (scan_start),
        .i_rd_col      (i_rd_col),
        .i_rd_row      (i_rd_row),
        .o_fits        (fits),
        .o_scan_done   (scan_done),
        .o_lines       (lines),
        .o_rd_cell     (o_rd_cell)
    );

    game_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_stop       (i_stop),
        .i_cmd_valid  (q_valid),
        .i_cmd        (q_cmd),
        .i_fits       (fits),
        .i_shape      (cur_shape),
        .i_scan_done  (scan_done),
        .i_lines      (lines),
        .o_pop        (pop),
        .o_active     (active_pos),
        .o_probe      (probe_pos),
        .o_place      (place),
        .o_clear      (clear),
        .o_scan_start (scan_start),
        .o_next       (next),
        .o_land       (o_land),
        .o_score      (o_score),
        .o_finish     (o_finish)
    );

endmodule

//--- verilog/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  logic                     i_stop,
    input  logic                     i_cmd_valid,
    input  tetris_pkg::cmd_e         i_cmd,
    input  logic                     i_fits,
    input  tetris_pkg::shape_t       i_shape,
    input  logic                     i_scan_done,
    input  logic [2:0]               i_lines,
    output logic                     o_pop,
    output tetris_pkg::piece_pos_t   o_active,
    output tetris_pkg::piece_pos_t   o_probe,
    output logic                     o_place,
    output logic                     o_clear,
    output logic                     o_scan_start,
    output logic                     o_next,
    output tetris_pkg::land_report_t o_land,
    output logic [9:0]               o_score,
    output logic                     o_finish
);
    import tetris_pkg::*;

    localparam int FALL_W  = $clog2(FALL_TICKS);
    localparam int STALL_W = $clog2(STALL_TICKS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_SETTLE,
        S_FALL,
        S_SCAN,
        S_SPAWN
    } state_e;

    state_e             state;
    state_e             state_nxt;
    piece_pos_t         active_nxt;
    piece_pos_t         spawn_pos;
    logic [FALL_W-1:0]  fall_cnt;
    logic [STALL_W-1:0] stall_cnt;
    logic               fall_due;
    logic               lock;
    logic [9:0]         points;

    assign fall_due  = (fall_cnt == FALL_W'(FALL_TICKS - 1));
    assign spawn_pos = '{shape: i_shape, dir: '0, col: COL_W'(SPAWN_COL), row: '0};

    // piece can no longer move down
    assign lock = !i_fits && (state == S_FALL || (state == S_WAIT && fall_due));
    assign o_place      = lock;
    assign o_scan_start = lock;

    always_comb begin
        case (i_lines)
            3'd1:    points = 10'd1;
            3'd2:    points = 10'd3;
            3'd3:    points = 10'd5;
            3'd4:    points = 10'd7;
            default: points = 10'd0;
        endcase
    end

    // candidate position for the board to test
    always_comb begin
        o_probe = o_active;
        if (state == S_SPAWN) begin
            o_probe = spawn_pos;
        end else if (state == S_FALL || (state == S_WAIT && fall_due)) begin
            o_probe.row = o_active.row + 1'b1;
        end else if (state == S_WAIT && i_cmd_valid) begin
            case (i_cmd)
                CMD_LEFT:   o_probe.col = o_active.col - 1'b1;
                CMD_RIGHT:  o_probe.col = o_active.col + 1'b1;
                CMD_ROTATE: o_probe.dir = o_active.dir + 1'b1;
                default:    o_probe.row = o_active.row + 1'b1;
            endcase
        end
    end

    always_comb begin
        state_nxt  = state;
        active_nxt = o_active;
        o_pop      = 1'b0;
        o_clear    = 1'b0;
        o_next     = 1'b0;
        case (state)
            S_IDLE: begin
                if (i_start) begin
                    o_clear   = 1'b1;
                    // leftover command from the last game is thrown away
                    o_pop     = i_cmd_valid;
                    state_nxt = S_SPAWN;
                end
            end
            S_WAIT: begin
                if (fall_due) begin
                    if (i_fits) begin
                        active_nxt = o_probe;
                    end else begin
                        state_nxt = S_SCAN;
                    end
                end else if (i_cmd_valid) begin
                    o_pop = 1'b1;
                    if (i_cmd == CMD_DROP) begin
                        state_nxt = S_FALL;
                    end else begin
                        if (i_fits) begin
                            active_nxt = o_probe;
                        end
                        state_nxt = S_SETTLE;
                    end
                end
            end
            S_SETTLE: begin
                if (stall_cnt == STALL_W'(STALL_TICKS - 1)) begin
                    state_nxt = S_WAIT;
                end
            end
            S_FALL: begin
                if (i_fits) begin
                    active_nxt = o_probe;
                end else begin
                    state_nxt = S_SCAN;
                end
            end
            S_SCAN: begin
                if (i_scan_done) begin
                    o_next    = 1'b1;
                    state_nxt = S_SPAWN;
                end
            end
            S_SPAWN: begin
                active_nxt = spawn_pos;
                state_nxt  = i_fits ? S_WAIT : S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
        if (i_stop) begin
            state_nxt = S_IDLE;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            o_active  <= '0;
            fall_cnt  <= '0;
            stall_cnt <= '0;
            o_score   <= '0;
            o_land    <= '0;
            o_finish  <= 1'b0;
        end else begin
            state    <= state_nxt;
            o_active <= active_nxt;
            o_land   <= '0;
            o_finish <= 1'b0;
            // gravity counts from spawn or from the last row moved
            if (state == S_SPAWN || active_nxt.row != o_active.row) begin
                fall_cnt <= '0;
            end else if (!fall_due) begin
                fall_cnt <= fall_cnt + 1'b1;
            end
            stall_cnt <= (state == S_SETTLE) ? stall_cnt + 1'b1 : '0;
            if (o_clear) begin
                o_score <= '0;
            end else if (state == S_SCAN && i_scan_done) begin
                o_score <= o_score + points;
                o_land  <= '{valid: 1'b1, lines: i_lines};
            end
            if (state == S_SPAWN && !i_fits) begin
                o_finish <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/board_store.sv
`timescale 1ns/1ps

module board_store (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_clear,
    input  tetris_pkg::piece_cells_t       i_probe,
    input  logic                           i_place,
    input  tetris_pkg::piece_cells_t       i_place_cells,
    input  logic [tetris_pkg::COLOR_W-1:0] i_place_color,
    input  logic                           i_scan_start,
    input  logic [tetris_pkg::COL_W-1:0]   i_rd_col,
    input  logic [tetris_pkg::ROW_W-1:0]   i_rd_row,
    output logic                           o_fits,
    output logic                           o_scan_done,
    output logic [2:0]                     o_lines,
    output logic [tetris_pkg::COLOR_W-1:0] o_rd_cell
);
    import tetris_pkg::*;

    logic [COLOR_W-1:0] board [BOARD_ROWS][BOARD_COLS];
    logic               scanning;
    logic [ROW_W-1:0]   scan_row;
    logic               row_full;

    // probe must sit on the board and on empty cells only
    always_comb begin
        o_fits = i_probe.in_bounds;
        for (int k = 0; k < 4; k++) begin
            if (board[i_probe.cells[k].row][i_probe.cells[k].col] != '0) begin
                o_fits = 1'b0;
            end
        end
    end

    always_comb begin
        row_full = 1'b1;
        for (int c = 0; c < BOARD_COLS; c++) begin
            if (board[scan_row][c] == '0) begin
                row_full = 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            board <= '{default: '0};
        end else if (i_clear) begin
            board <= '{default: '0};
        end else if (i_place && i_place_cells.in_bounds) begin
            for (int k = 0; k < 4; k++) begin
                board[i_place_cells.cells[k].row][i_place_cells.cells[k].col] <= i_place_color;
            end
        end else if (scanning && row_full) begin
            // everything above the full row moves down one
            board[0] <= '{default: '0};
            for (int r = 1; r < BOARD_ROWS; r++) begin
                if (r <= int'(scan_row)) begin
                    board[r] <= board[r-1];
                end
            end
        end
    end

    // top to bottom, one row per cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scanning    <= 1'b0;
            scan_row    <= '0;
            o_lines     <= '0;
            o_scan_done <= 1'b0;
        end else begin
            o_scan_done <= 1'b0;
            if (i_scan_start) begin
                scanning <= 1'b1;
                scan_row <= '0;
                o_lines  <= '0;
            end else if (scanning) begin
                o_lines <= o_lines + 3'(row_full);
                if (scan_row == ROW_W'(BOARD_ROWS - 1)) begin
                    scanning    <= 1'b0;
                    o_scan_done <= 1'b1;
                end else begin
                    scan_row <= scan_row + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_rd_cell <= board[i_rd_row][i_rd_col];
    end

endmodule

//--- verilog/piece_sequencer.sv
`timescale 1ns/1ps

module piece_sequencer (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_next,
    output tetris_pkg::shape_t o_shape
);
    import tetris_pkg::*;

    shape_t     shape_list [NUM_SHAPES];
    logic [2:0] adv_cnt;

    assign o_shape = shape_list[0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_SHAPES; i++) begin
                shape_list[i] <= shape_t'(i);
            end
            adv_cnt <= '0;
        end else if (i_next) begin
            if (adv_cnt == 3'(NUM_SHAPES - 1)) begin
                // reshuffle once per pass through the list
                shape_list[0] <= shape_list[3];
                shape_list[1] <= shape_list[5];
                shape_list[2] <= shape_list[4];
                shape_list[3] <= shape_list[0];
                shape_list[4] <= shape_list[6];
                shape_list[5] <= shape_list[2];
                shape_list[6] <= shape_list[1];
                adv_cnt       <= '0;
            end else begin
                for (int i = 0; i < NUM_SHAPES; i++) begin
                    shape_list[i] <= shape_list[(i + 1) % NUM_SHAPES];
                end
                adv_cnt <= adv_cnt + 3'd1;
            end
        end
    end

endmodule

//--- verilog/piece_geometry.sv
`timescale 1ns/1ps

module piece_geometry (
    input  tetris_pkg::piece_pos_t   i_pos,
    output tetris_pkg::piece_cells_t o_cells
);
    import tetris_pkg::*;

    always_comb begin
        int   ox;
        int   oy;
        int   dx;
        int   dy;
        int   c;
        int   r;
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            ox = 0;
            oy = 0;
            if (k > 0) begin
                ox = SHAPE_OFFSETS[i_pos.shape][k-1].dx;
                oy = SHAPE_OFFSETS[i_pos.shape][k-1].dy;
            end
            // quarter turns of (dx,dy) to (-dy,dx)
            case (i_pos.dir)
                2'd0: begin
                    dx = ox;
                    dy = oy;
                end
                2'd1: begin
                    dx = -oy;
                    dy = ox;
                end
                2'd2: begin
                    dx = -ox;
                    dy = -oy;
                end
                default: begin
                    dx = oy;
                    dy = -ox;
                end
            endcase
            c = int'(i_pos.col) + dx;
            r = int'(i_pos.row) + dy;
            if (c < 0 || c >= BOARD_COLS || r < 0 || r >= BOARD_ROWS) begin
                ok = 1'b0;
            end
            o_cells.cells[k].col = COL_W'(c);
            o_cells.cells[k].row = ROW_W'(r);
        end
        o_cells.in_bounds = ok;
    end

endmodule

//--- verilog/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  tetris_pkg::cmd_e i_cmd,
    input  logic             i_pop,
    output logic             o_valid,
    output tetris_pkg::cmd_e o_cmd,
    output logic             o_credit
);
    import tetris_pkg::*;

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    cmd_e             mem [CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign o_valid = (count != '0);
    assign o_cmd   = mem[rd_ptr];
    assign do_pop  = i_pop && o_valid;

    // sender holds a credit for every push, so no full check
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_cmd;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count + CNT_W'(i_push) - CNT_W'(do_pop);
            o_credit <= do_pop;
        end
    end

endmodule

//--- verilog/tetris_pkg.sv
package tetris_pkg;

    localparam int BOARD_COLS  = 10;
    localparam int BOARD_ROWS  = 20;
    localparam int COL_W       = 4;
    localparam int ROW_W       = 5;
    localparam int COLOR_W     = 3;
    localparam int NUM_SHAPES  = 7;
    localparam int SPAWN_COL   = 4;
    localparam int FALL_TICKS  = 4096;
    localparam int STALL_TICKS = 8;
    localparam int CMD_DEPTH   = 2;

    typedef logic [2:0] shape_t;
    typedef logic [1:0] dir_t;

    typedef struct packed {
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
    } cell_t;

    // cell 0 is the centre
    typedef struct packed {
        cell_t [3:0] cells;
        logic        in_bounds;
    } piece_cells_t;

    typedef struct packed {
        shape_t           shape;
        dir_t             dir;
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
    } piece_pos_t;

    typedef enum logic [1:0] {
        CMD_LEFT,
        CMD_RIGHT,
        CMD_ROTATE,
        CMD_DROP
    } cmd_e;

    typedef struct packed {
        logic       valid;
        logic [2:0] lines;
    } land_report_t;

    typedef struct packed {
        logic signed [2:0] dx;
        logic signed [2:0] dy;
    } offset_t;

    // block offsets from the centre at orientation 0, y grows downward
    localparam offset_t SHAPE_OFFSETS [NUM_SHAPES][3] = '{
        '{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{3'sd2, 3'sd0}},   // I
        '{'{3'sd1, 3'sd0}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd1}},    // O
        '{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{3'sd0, 3'sd1}},   // T
        '{'{3'sd1, 3'sd0}, '{-3'sd1, 3'sd1}, '{3'sd0, 3'sd1}},   // S
        '{'{-3'sd1, 3'sd0}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd1}},   // Z
        '{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{3'sd1, 3'sd1}},   // J
        '{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{-3'sd1, 3'sd1}}   // L
    };

endpackage
